/* all.f */
+incdir+hdl
hdl/hwce_data_pkg.sv
hdl/hwce_ctrl_pkg.sv
hdl/hwce_window_seq.sv
hdl/hwce_sop.sv
hdl/hwce_post_proc.sv
hdl/hwce_engine.sv
verification/hwce_engine_chk.sv
verification/hwce_scoreboard.sv
verification/tb_hwce_engine.sv

/* verification/tb_hwce_engine.sv */
// convolution engine testbench
`timescale 1ns/100ps
`include "hwce_params.svh"

module tb_hwce_engine;

   import hwce_data_pkg::*;
   import hwce_ctrl_pkg::*;

   localparam int NUM_PHASES   = 6;
   localparam int MAX_BEATS    = 4 * 15 * 15; // four windows of the largest size
   localparam int WATCHDOG_CYC = NUM_PHASES * MAX_BEATS * 4;
   localparam int DRAIN_CYC    = 64; // longest wait for the last outputs of a phase

   logic        clk;
   logic        rst_n;
   engine_cfg_t cfg_i;
   logic        engine_start_i;
   logic        clear_i;
   logic        x_valid_i;
   logic        x_ready_o;
   x_beat_t     x_data_i;
   logic        y_valid_o;
   logic        y_ready_i;
   y_beat_t     y_data_o;
   logic        busy_o;
   int          pending;
   int          data_errs;
   int          proto_errs;
   int          checked;
   int          windows_sent;
   int          tb_errs;
   logic [31:0] rng = 32'h39221aba;

   hwce_engine u_hwce_engine (.*);

   hwce_scoreboard u_sb (
      .*,
      .pending_o    (pending),
      .data_errs_o  (data_errs),
      .proto_errs_o (proto_errs),
      .checked_o    (checked)
   );

   bind hwce_engine hwce_engine_chk u_chk (.*);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   function automatic logic [31:0] next_rand(); // xorshift32
      rng = rng ^ (rng << 13);
      rng = rng ^ (rng >> 17);
      rng = rng ^ (rng << 5);
      return rng;
   endfunction

   function automatic pixel_t rand_val(logic big);
      logic [31:0] r;
      r = next_rand();
      return big ? pixel_t'(r[15:0]) : pixel_t'($signed(r[3:0])); // small keeps sums in range
   endfunction

   task automatic tick();
      logic [31:0] r;
      @(posedge clk);
      r = next_rand();
      y_ready_i <= (r[1:0] != 2'b00);
   endtask

   task automatic fill_beat(input logic big, output x_beat_t b);
      for (int c = 0; c < `HWCE_N_COL; c++)
         for (int p = 0; p < `HWCE_NPX; p++) b.pix[c][p] = rand_val(big);
      for (int r = 0; r < `HWCE_N_ROW; r++)
         for (int c = 0; c < `HWCE_N_COL; c++) b.wgt[r][c] = rand_val(big);
   endtask

   // phase 0 is 1x1 raw sums, 2 and 3 add bias and shift, 4 rectifies
   task automatic make_cfg(input int ph, output engine_cfg_t c, output logic big);
      logic [31:0] r;
      c = '0;
      c.fs_w = (ph == 0) ? fs_t'(1) : fs_t'(1 + next_rand() % 15);
      c.fs_h = (ph == 0) ? fs_t'(1) : fs_t'(1 + next_rand() % 15);
      r = next_rand();
      big = (ph == 3) || (ph >= 4 && r[0]);
      c.bias_en = (ph >= 2) && (ph < 5 || r[1]);
      c.relu_en = (ph == 4) || (ph == 5 && r[2]);
      c.qf = (ph < 2) ? qf_t'(0) : qf_t'(r[7:4] % 13);
      for (int i = 0; i < `HWCE_N_ROW; i++) c.bias[i] = pixel_t'($signed(r[19+i*6 -: 12]));
   endtask

   task automatic idle_probe(); // valid offered to an idle engine
      x_valid_i <= 1'b1;
      repeat (4) tick();
      x_valid_i <= 1'b0;
   endtask

   task automatic run_phase(input int ph);
      engine_cfg_t c;
      logic        big;
      logic [31:0] r;
      x_beat_t     b;
      int          n_win;
      int          sent;
      int          waited;
      logic        fired;
      make_cfg(ph, c, big);
      n_win = 2 + int'(next_rand() % 3);
      windows_sent += n_win;
      idle_probe();
      cfg_i <= c;
      engine_start_i <= 1'b1;
      tick();
      engine_start_i <= 1'b0;
      sent = 0;
      while (sent < n_win * int'(c.fs_w) * int'(c.fs_h)) begin
         tick();
         fired = x_valid_i && x_ready_o;
         if (fired) sent++;
         if (!x_valid_i || fired) begin
            r = next_rand();
            if (sent < n_win * int'(c.fs_w) * int'(c.fs_h) && r[2:0] != 3'b000) begin
               fill_beat(big, b);
               x_data_i <= b;
               x_valid_i <= 1'b1;
            end else begin
               x_valid_i <= 1'b0; // gap or done
            end
         end
      end
      waited = 0;
      do begin
         tick();
         waited++;
      end while (pending != 0 && waited < DRAIN_CYC); // drain outputs
      repeat (3) tick();
      clear_i <= 1'b1;
      tick();
      clear_i <= 1'b0;
   endtask

   initial begin
      rst_n = 1'b1;
      cfg_i = '0;
      engine_start_i = 1'b0;
      clear_i = 1'b0;
      x_valid_i = 1'b0;
      x_data_i = '0;
      y_ready_i = 1'b0;
      windows_sent = 0;
      tb_errs = 0;
      #1 rst_n = 1'b0; // falling edge after time zero
      repeat (8) @(posedge clk);
      rst_n <= 1'b1;
      for (int ph = 0; ph < NUM_PHASES; ph++) run_phase(ph);
      idle_probe();
      if (checked != windows_sent) begin
         $display("%0d windows were sent but %0d outputs were checked", windows_sent, checked);
         tb_errs++;
      end
      $display("errors: data %0d, protocol %0d, assertion %0d, count %0d", data_errs,
               proto_errs, u_hwce_engine.u_chk.fail_cnt, tb_errs);
      if (data_errs + proto_errs + tb_errs + u_hwce_engine.u_chk.fail_cnt == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

   initial begin
      repeat (WATCHDOG_CYC) @(posedge clk);
      $display("watchdog expired after %0d cycles, the run did not complete", WATCHDOG_CYC);
      $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

/* verification/hwce_scoreboard.sv */
// engine reference model and output compare
`timescale 1ns/100ps
`include "hwce_params.svh"

module hwce_scoreboard (
   input  logic                       clk,
   input  logic                       rst_n,
   input  hwce_ctrl_pkg::engine_cfg_t cfg_i,
   input  logic                       engine_start_i,
   input  logic                       clear_i,
   input  logic                       busy_o,
   input  logic                       x_valid_i,
   input  logic                       x_ready_o,
   input  hwce_data_pkg::x_beat_t     x_data_i,
   input  logic                       y_valid_o,
   input  logic                       y_ready_i,
   input  hwce_data_pkg::y_beat_t     y_data_o,
   output int                         pending_o,
   output int                         data_errs_o,
   output int                         proto_errs_o,
   output int                         checked_o
);

   import hwce_data_pkg::*;
   import hwce_ctrl_pkg::*;

   engine_cfg_t cfg_q; // copy taken at start
   logic        busy_exp;
   longint      acc [`HWCE_N_ROW][`HWCE_NPX];
   int          beat_cnt;
   y_beat_t     exp_q [$];

   // shift first, then bias, saturate and rectify
   function automatic pixel_t expect_pixel(longint sum, int r);
      longint v;
      v = sum >>> cfg_q.qf;
      if (cfg_q.bias_en) v = v + longint'(cfg_q.bias[r]);
      if (v > 32767) v = 32767;
      else if (v < -32768) v = -32768;
      if (cfg_q.relu_en && v < 0) v = 0;
      return pixel_t'(v);
   endfunction

   task automatic clear_window();
      for (int r = 0; r < `HWCE_N_ROW; r++)
         for (int p = 0; p < `HWCE_NPX; p++) acc[r][p] = 0;
      beat_cnt = 0;
   endtask

   task automatic take_beat();
      y_beat_t e;
      for (int r = 0; r < `HWCE_N_ROW; r++)
         for (int p = 0; p < `HWCE_NPX; p++)
            for (int c = 0; c < `HWCE_N_COL; c++)
               acc[r][p] += longint'(x_data_i.pix[c][p]) * longint'(x_data_i.wgt[r][c]);
      beat_cnt++;
      if (beat_cnt == int'(cfg_q.fs_w) * int'(cfg_q.fs_h)) begin // window closed
         for (int r = 0; r < `HWCE_N_ROW; r++)
            for (int p = 0; p < `HWCE_NPX; p++) e.pix[r][p] = expect_pixel(acc[r][p], r);
         exp_q.push_back(e);
         clear_window();
      end
   endtask

   task automatic compare_out();
      y_beat_t e;
      if (exp_q.size() == 0) begin
         $display("output beat arrived with no window pending");
         proto_errs_o++;
      end else begin
         e = exp_q.pop_front();
         checked_o++;
         for (int r = 0; r < `HWCE_N_ROW; r++)
            for (int p = 0; p < `HWCE_NPX; p++)
               if (y_data_o.pix[r][p] !== e.pix[r][p]) begin
                  $display("Fail y_data_o.pix[%0d][%0d]: got %h expected %h",
                           r, p, y_data_o.pix[r][p], e.pix[r][p]);
                  data_errs_o++;
               end
      end
   endtask

   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         busy_exp = 1'b0;
         cfg_q = '0;
         exp_q.delete();
         clear_window();
         data_errs_o = 0;
         proto_errs_o = 0;
         checked_o = 0;
         pending_o <= 0;
      end else begin
         if (busy_o !== busy_exp) begin
            $display("Fail busy_o: got %h expected %h", busy_o, busy_exp);
            proto_errs_o++;
         end
         if (!busy_exp && (x_ready_o || y_valid_o)) begin // idle engine stays quiet
            $display("Fail x_ready_o/y_valid_o: got %h/%h expected 0/0", x_ready_o, y_valid_o);
            proto_errs_o++;
         end
         if (y_valid_o && y_ready_i) compare_out();
         if (clear_i) begin
            if (exp_q.size() != 0) begin
               $display("%0d expected output beats were lost at clear", exp_q.size());
               proto_errs_o++;
            end
            exp_q.delete();
            clear_window();
            busy_exp = 1'b0;
         end else begin
            if (x_valid_i && x_ready_o) take_beat();
            if (engine_start_i && !busy_exp) begin
               busy_exp = 1'b1;
               cfg_q = cfg_i;
            end
         end
         pending_o <= exp_q.size();
      end
   end

endmodule

/* verification/hwce_engine_chk.sv */
// handshake and reset assertions
`timescale 1ns/100ps

module hwce_engine_chk (
   input logic                   clk,
   input logic                   rst_n,
   input logic                   clear_i,
   input logic                   x_ready_o,
   input logic                   y_valid_o,
   input logic                   y_ready_i,
   input hwce_data_pkg::y_beat_t y_data_o
);

   int unsigned fail_cnt = 0; // failed assertion count
   logic        stalled;

   assign stalled = y_valid_o && !y_ready_i;

   // nothing offered or accepted in reset
   a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !y_valid_o && !x_ready_o)
      else begin
         $error("y_valid_o or x_ready_o high during reset");
         fail_cnt++;
      end

   a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
      stalled && !clear_i |=> y_valid_o && $stable(y_data_o))
      else begin
         $error("output beat changed while stalled");
         fail_cnt++;
      end

   // back-pressure reaches the input side
   a_stall_in: assert property (@(posedge clk) disable iff (!rst_n) stalled |-> !x_ready_o)
      else begin
         $error("x_ready_o high while the output is stalled");
         fail_cnt++;
      end

endmodule

/* hdl/hwce_engine.sv */
// convolution engine top level
`timescale 1ns/100ps
`include "hwce_params.svh"

module hwce_engine (
   input  logic                       clk,
   input  logic                       rst_n,
   input  hwce_ctrl_pkg::engine_cfg_t cfg_i,
   input  logic                       engine_start_i,
   input  logic                       clear_i,
   input  logic                       x_valid_i,
   output logic                       x_ready_o,
   input  hwce_data_pkg::x_beat_t     x_data_i,
   output logic                       y_valid_o,
   input  logic                       y_ready_i,
   output hwce_data_pkg::y_beat_t     y_data_o,
   output logic                       busy_o
);

   import hwce_data_pkg::*;
   import hwce_ctrl_pkg::*;

   engine_cfg_t                    cfg_q; // latched at start
   logic                           advance;
   logic                           x_fire;
   logic                           win_last;
   logic [`HWCE_N_ROW-1:0]         acc_valid;
   row_acc_t [`HWCE_N_ROW-1:0]     row_acc;

   hwce_window_seq u_seq (
      .clk            (clk),
      .rst_n          (rst_n),
      .cfg_i          (cfg_i),
      .engine_start_i (engine_start_i),
      .clear_i        (clear_i),
      .x_valid_i      (x_valid_i),
      .advance_i      (advance),
      .x_ready_o      (x_ready_o),
      .x_fire_o       (x_fire),
      .win_last_o     (win_last),
      .busy_o         (busy_o),
      .cfg_o          (cfg_q)
   );

   // every row sees all columns, weights are picked per row
   for (genvar r = 0; r < `HWCE_N_ROW; r++) begin : g_row
      hwce_sop u_sop (
         .clk         (clk),
         .rst_n       (rst_n),
         .clear_i     (clear_i),
         .advance_i   (advance),
         .x_fire_i    (x_fire),
         .win_last_i  (win_last),
         .pix_i       (x_data_i.pix),
         .wgt_i       (x_data_i.wgt[r]),
         .acc_valid_o (acc_valid[r]),
         .acc_o       (row_acc[r])
      );
   end

   hwce_post_proc u_post (
      .clk         (clk),
      .rst_n       (rst_n),
      .clear_i     (clear_i),
      .cfg_i       (cfg_q),
      .acc_valid_i (acc_valid[0]), // rows run in lockstep
      .acc_i       (row_acc),
      .y_ready_i   (y_ready_i),
      .y_valid_o   (y_valid_o),
      .y_data_o    (y_data_o),
      .advance_o   (advance)
   );

endmodule

/* hdl/hwce_post_proc.sv */
// output post-processing stage
`timescale 1ns/100ps
`include "hwce_params.svh"

module hwce_post_proc (
   input  logic                                          clk,
   input  logic                                          rst_n,
   input  logic                                          clear_i,
   input  hwce_ctrl_pkg::engine_cfg_t                    cfg_i,
   input  logic                                          acc_valid_i,
   input  hwce_data_pkg::row_acc_t [`HWCE_N_ROW-1:0]     acc_i,
   input  logic                                          y_ready_i,
   output logic                                          y_valid_o,
   output hwce_data_pkg::y_beat_t                        y_data_o,
   output logic                                          advance_o
);

   import hwce_data_pkg::*;
   import hwce_ctrl_pkg::*;

   // 16 bit signed range on the accumulator scale
   localparam acc_t sat_max = acc_t'((1 << (`HWCE_CONV_WIDTH-1)) - 1);
   localparam acc_t sat_min = acc_t'(-(1 << (`HWCE_CONV_WIDTH-1)));

   y_beat_t y_d;

   function automatic pixel_t post_pixel(acc_t sum, pixel_t bias, engine_cfg_t cfg);
      acc_t   val;
      pixel_t res;
      val = sum >>> cfg.qf; // arithmetic, keeps the sign
      if (cfg.bias_en) begin
         val = val + acc_t'(bias);
      end
      if (val > sat_max) begin
         res = pixel_t'(sat_max);
      end else if (val < sat_min) begin
         res = pixel_t'(sat_min);
      end else begin
         res = val[`HWCE_CONV_WIDTH-1:0];
      end
      if (cfg.relu_en && res[`HWCE_CONV_WIDTH-1]) begin
         res = '0; // rectifier
      end
      return res;
   endfunction

   always_comb begin
      for (int r = 0; r < `HWCE_N_ROW; r++) begin
         for (int p = 0; p < `HWCE_NPX; p++) begin
            y_d.pix[r][p] = post_pixel(acc_i[r][p], cfg_i.bias[r], cfg_i);
         end
      end
   end

   // stall only when a result waits and the sink is not ready
   assign advance_o = !(y_valid_o && !y_ready_i);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         y_valid_o <= 1'b0;
      end else if (clear_i) begin
         y_valid_o <= 1'b0;
      end else if (advance_o) begin
         y_valid_o <= acc_valid_i; // drops after transfer unless a new window is ready
      end
   end

   // data holds while stalled
   always_ff @(posedge clk) begin
      if (advance_o && acc_valid_i) begin
         y_data_o <= y_d;
      end
   end

endmodule

/* hdl/hwce_sop.sv */
// per-row sum of products
`timescale 1ns/100ps
`include "hwce_params.svh"

module hwce_sop (
   input  logic                                                     clk,
   input  logic                                                     rst_n,
   input  logic                                                     clear_i,
   input  logic                                                     advance_i,
   input  logic                                                     x_fire_i,
   input  logic                                                     win_last_i,
   input  hwce_data_pkg::pixel_t [`HWCE_N_COL-1:0][`HWCE_NPX-1:0]   pix_i,
   input  hwce_data_pkg::weight_t [`HWCE_N_COL-1:0]                 wgt_i,
   output logic                                                     acc_valid_o,
   output hwce_data_pkg::row_acc_t                                  acc_o
);

   import hwce_data_pkg::*;

   pixel_t [`HWCE_N_COL-1:0][`HWCE_NPX-1:0] pix_q; // dsp input regs
   weight_t [`HWCE_N_COL-1:0]              wgt_q;
   logic                                   s0_valid_q;
   logic                                   s0_last_q;
   row_acc_t                               sop_d;
   row_acc_t                               sop_q; // stage 1, column summed products
   logic                                   s1_valid_q;
   logic                                   s1_last_q;
   row_acc_t                               acc_q; // running window sum
   row_acc_t                               acc_sum;

   always_comb begin
      logic signed [2*`HWCE_CONV_WIDTH-1:0] prod;
      for (int p = 0; p < `HWCE_NPX; p++) begin
         sop_d[p] = '0;
         for (int c = 0; c < `HWCE_N_COL; c++) begin
            prod     = $signed(pix_q[c][p]) * $signed(wgt_q[c]);
            sop_d[p] = sop_d[p] + acc_t'(prod);
         end
      end
   end

   always_comb begin
      for (int p = 0; p < `HWCE_NPX; p++) begin
         acc_sum[p] = acc_q[p] + sop_q[p];
      end
   end

   // valid and last travel with the data, everything holds on a stall
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         s0_valid_q  <= 1'b0;
         s0_last_q   <= 1'b0;
         s1_valid_q  <= 1'b0;
         s1_last_q   <= 1'b0;
         acc_valid_o <= 1'b0;
         acc_q       <= '0;
      end else if (clear_i) begin
         s0_valid_q  <= 1'b0;
         s0_last_q   <= 1'b0;
         s1_valid_q  <= 1'b0;
         s1_last_q   <= 1'b0;
         acc_valid_o <= 1'b0;
         acc_q       <= '0;
      end else if (advance_i) begin
         s0_valid_q  <= x_fire_i;
         s0_last_q   <= x_fire_i && win_last_i;
         s1_valid_q  <= s0_valid_q;
         s1_last_q   <= s0_last_q;
         acc_valid_o <= s1_valid_q && s1_last_q;
         if (s1_valid_q) begin
            acc_q <= s1_last_q ? row_acc_t'(0) : acc_sum; // restart on window close
         end
      end
   end

   always_ff @(posedge clk) begin
      if (x_fire_i) begin
         pix_q <= pix_i;
         wgt_q <= wgt_i;
      end
      if (advance_i && s0_valid_q) begin
         sop_q <= sop_d;
      end
      if (advance_i && s1_valid_q && s1_last_q) begin
         acc_o <= acc_sum; // window total
      end
   end

endmodule

/* hdl/hwce_window_seq.sv */
// filter window sequencer
`timescale 1ns/100ps

module hwce_window_seq (
   input  logic                       clk,
   input  logic                       rst_n,
   input  hwce_ctrl_pkg::engine_cfg_t cfg_i,
   input  logic                       engine_start_i,
   input  logic                       clear_i,
   input  logic                       x_valid_i,
   input  logic                       advance_i,
   output logic                       x_ready_o,
   output logic                       x_fire_o,
   output logic                       win_last_o,
   output logic                       busy_o,
   output hwce_ctrl_pkg::engine_cfg_t cfg_o
);

   import hwce_ctrl_pkg::*;

   seq_state_t  state_q;
   seq_state_t  state_d;
   engine_cfg_t cfg_q;
   fs_t         cnt_w_q; // column position inside the window
   fs_t         cnt_h_q; // line position inside the window
   logic        w_end;
   logic        h_end;
   logic        start;

   assign start = (state_q == SEQ_IDLE) && engine_start_i;

   always_comb begin
      state_d = state_q;
      if (clear_i) begin
         state_d = SEQ_IDLE; // clear beats start
      end else if (start) begin
         state_d = SEQ_RUN;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q <= SEQ_IDLE;
         cfg_q   <= '0;
      end else begin
         state_q <= state_d;
         if (start && !clear_i) begin
            cfg_q <= cfg_i;
         end
      end
   end

   // accept only while running and the pipeline moves
   assign x_ready_o = (state_q == SEQ_RUN) && advance_i;
   assign x_fire_o  = x_valid_i && x_ready_o;

   // width counts first, height steps when width wraps
   assign w_end      = (cnt_w_q == cfg_q.fs_w - fs_t'(1));
   assign h_end      = (cnt_h_q == cfg_q.fs_h - fs_t'(1));
   assign win_last_o = w_end && h_end;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cnt_w_q <= '0;
         cnt_h_q <= '0;
      end else if (clear_i) begin
         cnt_w_q <= '0;
         cnt_h_q <= '0;
      end else if (x_fire_o) begin
         if (w_end) begin
            cnt_w_q <= '0;
            cnt_h_q <= h_end ? fs_t'(0) : cnt_h_q + fs_t'(1); // next window starts at 0,0
         end else begin
            cnt_w_q <= cnt_w_q + fs_t'(1);
         end
      end
   end

   assign busy_o = (state_q == SEQ_RUN);
   assign cfg_o  = cfg_q;

endmodule

/* hdl/hwce_ctrl_pkg.sv */
// convolution engine control types
`include "hwce_params.svh"

package hwce_ctrl_pkg;

   typedef logic [`HWCE_FS_WIDTH-1:0] fs_t; // filter side and window position
   typedef logic [`HWCE_QF_WIDTH-1:0] qf_t;

   // sampled once at engine start
   typedef struct packed {
      fs_t                                       fs_w;
      fs_t                                       fs_h;
      qf_t                                       qf;
      logic                                      bias_en;
      logic                                      relu_en;
      hwce_data_pkg::pixel_t [`HWCE_N_ROW-1:0]   bias;
   } engine_cfg_t;

   typedef enum logic {
      SEQ_IDLE = 1'b0,
      SEQ_RUN  = 1'b1
   } seq_state_t;

endpackage

/* hdl/hwce_data_pkg.sv */
// convolution engine data types
`include "hwce_params.svh"

package hwce_data_pkg;

   typedef logic signed [`HWCE_CONV_WIDTH-1:0] pixel_t;
   typedef logic signed [`HWCE_CONV_WIDTH-1:0] weight_t;
   typedef logic signed [`HWCE_SUM_WIDTH-1:0]  acc_t;

   // one input beat: all columns plus a weight per row and column
   typedef struct packed {
      pixel_t  [`HWCE_N_COL-1:0][`HWCE_NPX-1:0]   pix;
      weight_t [`HWCE_N_ROW-1:0][`HWCE_N_COL-1:0] wgt;
   } x_beat_t;

   // one output beat, every row at once
   typedef struct packed {
      pixel_t [`HWCE_N_ROW-1:0][`HWCE_NPX-1:0] pix;
   } y_beat_t;

   // window totals of a single row
   typedef acc_t [`HWCE_NPX-1:0] row_acc_t;

endpackage

/* hdl/hwce_params.svh */
// convolution engine parameters
`ifndef HWCE_PARAMS_SVH
`define HWCE_PARAMS_SVH

// datapath widths
`define HWCE_CONV_WIDTH 16 // pixel, weight and output
`define HWCE_SUM_WIDTH  48 // accumulator, fits a dsp48 adder

// array dimensions
`define HWCE_NPX   4 // pixels per column per beat
`define HWCE_N_ROW 2 // output rows
`define HWCE_N_COL 2 // input columns

// configuration field widths
`define HWCE_FS_WIDTH 4 // filter side, 1 to 15
`define HWCE_QF_WIDTH 5 // fixed point shift

`endif
